// ==== hw/ex_pkg.sv ====
package ex_pkg;

    // data, address and pc word
    typedef logic [31:0] word_t;

    // register file index
    typedef logic [4:0] reg_addr_t;

    // shift amount, low five bits of the second operand
    typedef logic [4:0] shamt_t;

    // decoded instruction class
    typedef logic [3:0] inst_class_t;

    // function select, meaning depends on the class
    typedef logic [3:0] func_t;

    // instruction classes from decode
    localparam inst_class_t CLASS_NOP    = 4'd0;
    localparam inst_class_t CLASS_LUI    = 4'd1;
    localparam inst_class_t CLASS_AUIPC  = 4'd2;
    localparam inst_class_t CLASS_JAL    = 4'd3;
    localparam inst_class_t CLASS_JALR   = 4'd4;
    localparam inst_class_t CLASS_BRANCH = 4'd5;
    localparam inst_class_t CLASS_LOAD   = 4'd6;
    localparam inst_class_t CLASS_STORE  = 4'd7;
    localparam inst_class_t CLASS_OP_IMM = 4'd8;
    localparam inst_class_t CLASS_OP     = 4'd9;

    // alu functions, for OP and OP_IMM
    localparam func_t FUNC_ADD  = 4'd0;
    localparam func_t FUNC_SUB  = 4'd1;
    localparam func_t FUNC_SLL  = 4'd2;
    localparam func_t FUNC_SLT  = 4'd3;
    localparam func_t FUNC_SLTU = 4'd4;
    localparam func_t FUNC_XOR  = 4'd5;
    localparam func_t FUNC_SRL  = 4'd6;
    localparam func_t FUNC_SRA  = 4'd7;
    localparam func_t FUNC_OR   = 4'd8;
    localparam func_t FUNC_AND  = 4'd9;

    // branch conditions, same numbering as funct3
    localparam func_t FUNC_BEQ  = 4'd0;
    localparam func_t FUNC_BNE  = 4'd1;
    localparam func_t FUNC_BLT  = 4'd4;
    localparam func_t FUNC_BGE  = 4'd5;
    localparam func_t FUNC_BLTU = 4'd6;
    localparam func_t FUNC_BGEU = 4'd7;

    // memory op codes, zero means no access
    localparam func_t FUNC_MEM_NONE = 4'd0;
    localparam func_t FUNC_LB  = 4'd1;
    localparam func_t FUNC_LH  = 4'd2;
    localparam func_t FUNC_LW  = 4'd3;
    localparam func_t FUNC_LBU = 4'd4;
    localparam func_t FUNC_LHU = 4'd5;
    localparam func_t FUNC_SB  = 4'd6;
    localparam func_t FUNC_SH  = 4'd7;
    localparam func_t FUNC_SW  = 4'd8;

    // return address distance for jal and jalr
    localparam word_t LINK_OFFSET = 32'd4;

    // result slots owned by the memory stage
    localparam int CREDIT_MAX = 2;

    // must hold 0 .. CREDIT_MAX
    typedef logic [$clog2(CREDIT_MAX + 1) - 1:0] credit_cnt_t;

endpackage

// ==== hw/ex_alu.sv ====
module ex_alu (
    input  ex_pkg::word_t a_i,
    input  ex_pkg::word_t b_i,
    input  ex_pkg::func_t func_i,
    output ex_pkg::word_t result_o
);

    // shifts only look at the low five bits
    ex_pkg::shamt_t shamt;

    // compare results, single bit each
    logic lt_signed;
    logic lt_unsigned;

    assign shamt = b_i[4:0];

    assign lt_signed   = $signed(a_i) < $signed(b_i);
    assign lt_unsigned = a_i < b_i;

    always_comb begin
        case (func_i)
            ex_pkg::FUNC_ADD: begin
                result_o = a_i + b_i;
            end
            ex_pkg::FUNC_SUB: begin
                result_o = a_i - b_i;
            end
            ex_pkg::FUNC_SLL: begin
                result_o = a_i << shamt;
            end
            ex_pkg::FUNC_SLT: begin
                // zero extended flag
                result_o = {31'd0, lt_signed};
            end
            ex_pkg::FUNC_SLTU: begin
                result_o = {31'd0, lt_unsigned};
            end
            ex_pkg::FUNC_XOR: begin
                result_o = a_i ^ b_i;
            end
            ex_pkg::FUNC_SRL: begin
                result_o = a_i >> shamt;
            end
            ex_pkg::FUNC_SRA: begin
                // sign fill from bit 31
                result_o = ex_pkg::word_t'($signed(a_i) >>> shamt);
            end
            ex_pkg::FUNC_OR: begin
                result_o = a_i | b_i;
            end
            ex_pkg::FUNC_AND: begin
                result_o = a_i & b_i;
            end
            default: begin
                // unknown code gives zero
                result_o = '0;
            end
        endcase
    end

endmodule

// ==== hw/ex_branch_unit.sv ====
module ex_branch_unit (
    input  ex_pkg::inst_class_t inst_class_i,
    input  ex_pkg::func_t       func_i,
    input  ex_pkg::word_t       pc_i,
    input  ex_pkg::word_t       imm_i,
    input  ex_pkg::word_t       reg1_i,
    input  ex_pkg::word_t       reg2_i,
    output logic                redirect_o,
    output ex_pkg::word_t       target_o,
    output ex_pkg::word_t       link_o
);

    // branch condition for the current func code
    logic cond;

    always_comb begin
        case (func_i)
            ex_pkg::FUNC_BEQ:  cond = reg1_i == reg2_i;
            ex_pkg::FUNC_BNE:  cond = reg1_i != reg2_i;
            ex_pkg::FUNC_BLT:  cond = $signed(reg1_i) < $signed(reg2_i);
            ex_pkg::FUNC_BGE:  cond = $signed(reg1_i) >= $signed(reg2_i);
            ex_pkg::FUNC_BLTU: cond = reg1_i < reg2_i;
            ex_pkg::FUNC_BGEU: cond = reg1_i >= reg2_i;
            default:           cond = 1'b0;
        endcase
    end

    // jalr is register relative and everything else pc relative
    assign target_o = (inst_class_i == ex_pkg::CLASS_JALR) ? reg1_i + imm_i : pc_i + imm_i;

    // return address
    assign link_o = pc_i + ex_pkg::LINK_OFFSET;

    always_comb begin
        case (inst_class_i)
            ex_pkg::CLASS_JAL,
            ex_pkg::CLASS_JALR: begin
                // jumps are unconditional
                redirect_o = 1'b1;
            end
            ex_pkg::CLASS_BRANCH: begin
                redirect_o = cond;
            end
            default: begin
                redirect_o = 1'b0;
            end
        endcase
    end

endmodule

// ==== hw/ex_credit_reg.sv ====
module ex_credit_reg (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              issue_i,
    input  logic              credit_return_i,
    input  ex_pkg::reg_addr_t wd_i,
    input  logic              wreg_i,
    input  ex_pkg::word_t     wdata_i,
    input  logic              redirect_i,
    input  ex_pkg::word_t     redirect_pc_i,
    input  ex_pkg::func_t     mem_op_i,
    input  ex_pkg::word_t     mem_wdata_i,
    output logic              has_credit_o,
    output logic              out_valid_o,
    output ex_pkg::reg_addr_t wd_o,
    output logic              wreg_o,
    output ex_pkg::word_t     wdata_o,
    output logic              redirect_o,
    output ex_pkg::word_t     redirect_pc_o,
    output ex_pkg::func_t     mem_op_o,
    output ex_pkg::word_t     mem_wdata_o
);

    localparam ex_pkg::credit_cnt_t CREDIT_FULL = ex_pkg::credit_cnt_t'(ex_pkg::CREDIT_MAX);

    // free slots downstream
    ex_pkg::credit_cnt_t credit_q;

    // issue spends, return refunds, both at once cancel
    always_ff @(posedge clk) begin
        if (rst_i) begin
            credit_q <= CREDIT_FULL;
        end else if (issue_i && !credit_return_i) begin
            credit_q <= credit_q - 1'b1;
        end else if (credit_return_i && !issue_i) begin
            credit_q <= credit_q + 1'b1;
        end
    end

    assign has_credit_o = credit_q != '0;

    // control bits, cleared on idle cycles
    always_ff @(posedge clk) begin
        if (rst_i) begin
            out_valid_o <= 1'b0;
            wreg_o      <= 1'b0;
            redirect_o  <= 1'b0;
        end else begin
            out_valid_o <= issue_i;
            wreg_o      <= issue_i && wreg_i;
            redirect_o  <= issue_i && redirect_i;
        end
    end

    // payload, only meaningful with out_valid_o
    always_ff @(posedge clk) begin
        if (issue_i) begin
            wd_o          <= wd_i;
            wdata_o       <= wdata_i;
            redirect_pc_o <= redirect_pc_i;
            mem_op_o      <= mem_op_i;
            mem_wdata_o   <= mem_wdata_i;
        end
    end

    // counter stays in range
    assert property (@(posedge clk) disable iff (rst_i)
        credit_q <= CREDIT_FULL)
        else $error("credit count above limit");

    // memory stage cannot free a slot it never filled
    assert property (@(posedge clk) disable iff (rst_i)
        credit_return_i |-> credit_q != CREDIT_FULL)
        else $error("credit returned while count full");

    // no issue without a free slot
    assert property (@(posedge clk) disable iff (rst_i)
        issue_i |-> has_credit_o)
        else $error("issue without credit");

endmodule

// ==== hw/ex_stage.sv ====
module ex_stage (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                in_valid_i,
    input  ex_pkg::word_t       pc_i,
    input  ex_pkg::inst_class_t inst_class_i,
    input  ex_pkg::func_t       func_i,
    input  ex_pkg::word_t       imm_i,
    input  ex_pkg::word_t       reg1_i,
    input  ex_pkg::word_t       reg2_i,
    input  ex_pkg::reg_addr_t   wd_i,
    input  logic                credit_return_i,
    output logic                in_ready_o,
    output logic                out_valid_o,
    output ex_pkg::reg_addr_t   wd_o,
    output logic                wreg_o,
    output ex_pkg::word_t       wdata_o,
    output logic                redirect_o,
    output ex_pkg::word_t       redirect_pc_o,
    output ex_pkg::func_t       mem_op_o,
    output ex_pkg::word_t       mem_wdata_o
);

    // alu operands and function
    ex_pkg::word_t alu_a;
    ex_pkg::word_t alu_b;
    ex_pkg::func_t alu_func;
    ex_pkg::word_t alu_result;

    // branch unit results
    logic          br_redirect;
    ex_pkg::word_t br_target;
    ex_pkg::word_t br_link;

    // unregistered writeback fields
    logic              wreg;
    ex_pkg::reg_addr_t wd;
    ex_pkg::word_t     wdata;
    ex_pkg::func_t     mem_op;
    ex_pkg::word_t     mem_wdata;

    logic has_credit;
    logic issue;

    // operand select per class
    always_comb begin
        alu_a    = '0;
        alu_b    = imm_i;
        alu_func = ex_pkg::FUNC_ADD;
        case (inst_class_i)
            ex_pkg::CLASS_OP: begin
                alu_a    = reg1_i;
                alu_b    = reg2_i;
                alu_func = func_i;
            end
            ex_pkg::CLASS_OP_IMM: begin
                alu_a    = reg1_i;
                alu_func = func_i;
            end
            ex_pkg::CLASS_LOAD,
            ex_pkg::CLASS_STORE: begin
                // effective address
                alu_a = reg1_i;
            end
            ex_pkg::CLASS_AUIPC: begin
                alu_a = pc_i;
            end
            default: begin
                // lui is zero plus imm
                alu_a = '0;
            end
        endcase
    end

    ex_alu u_alu (
        .a_i      (alu_a),
        .b_i      (alu_b),
        .func_i   (alu_func),
        .result_o (alu_result)
    );

    ex_branch_unit u_branch (
        .inst_class_i (inst_class_i),
        .func_i       (func_i),
        .pc_i         (pc_i),
        .imm_i        (imm_i),
        .reg1_i       (reg1_i),
        .reg2_i       (reg2_i),
        .redirect_o   (br_redirect),
        .target_o     (br_target),
        .link_o       (br_link)
    );

    // writeback and memory fields per class
    always_comb begin
        wreg      = 1'b0;
        wdata     = '0;
        mem_op    = ex_pkg::FUNC_MEM_NONE;
        mem_wdata = '0;
        case (inst_class_i)
            ex_pkg::CLASS_LUI,
            ex_pkg::CLASS_AUIPC,
            ex_pkg::CLASS_OP_IMM,
            ex_pkg::CLASS_OP: begin
                wreg  = 1'b1;
                wdata = alu_result;
            end
            ex_pkg::CLASS_JAL,
            ex_pkg::CLASS_JALR: begin
                wreg  = 1'b1;
                wdata = br_link;
            end
            ex_pkg::CLASS_LOAD: begin
                wreg   = 1'b1;
                wdata  = alu_result;
                mem_op = func_i;
            end
            ex_pkg::CLASS_STORE: begin
                // address in wdata, data from rs2
                wdata     = alu_result;
                mem_op    = func_i;
                mem_wdata = reg2_i;
            end
            default: begin
            end
        endcase
        // no destination when nothing is written
        wd = wreg ? wd_i : '0;
    end

    // accept only with a free slot
    assign issue      = in_valid_i && has_credit;
    assign in_ready_o = has_credit;

    ex_credit_reg u_out (
        .clk             (clk),
        .rst_i           (rst_i),
        .issue_i         (issue),
        .credit_return_i (credit_return_i),
        .wd_i            (wd),
        .wreg_i          (wreg),
        .wdata_i         (wdata),
        .redirect_i      (br_redirect),
        .redirect_pc_i   (br_target),
        .mem_op_i        (mem_op),
        .mem_wdata_i     (mem_wdata),
        .has_credit_o    (has_credit),
        .out_valid_o     (out_valid_o),
        .wd_o            (wd_o),
        .wreg_o          (wreg_o),
        .wdata_o         (wdata_o),
        .redirect_o      (redirect_o),
        .redirect_pc_o   (redirect_pc_o),
        .mem_op_o        (mem_op_o),
        .mem_wdata_o     (mem_wdata_o)
    );

endmodule

// ==== test/tb_ex_stage.sv ====
module tb_ex_stage;
    timeunit 1ns;
    timeprecision 100ps;

    // 300 instructions at 10 cycles each plus margin
    localparam int CYCLE_LIMIT = 300 * 10 + 200;

    // one expected result where the check flags mark the fields that matter
    typedef struct packed {
        logic              wreg;
        logic              redirect;
        logic              check_wdata;
        logic              check_mem;
        ex_pkg::reg_addr_t wd;
        ex_pkg::word_t     wdata;
        ex_pkg::word_t     target;
        ex_pkg::func_t     mem_op;
        ex_pkg::word_t     mem_wdata;
    } exp_t;

    logic                clk;
    logic                rst_i;
    logic                in_valid_i;
    ex_pkg::word_t       pc_i;
    ex_pkg::inst_class_t inst_class_i;
    ex_pkg::func_t       func_i;
    ex_pkg::word_t       imm_i;
    ex_pkg::word_t       reg1_i;
    ex_pkg::word_t       reg2_i;
    ex_pkg::reg_addr_t   wd_i;
    logic                credit_return_i;
    logic                in_ready_o;
    logic                out_valid_o;
    ex_pkg::reg_addr_t   wd_o;
    logic                wreg_o;
    ex_pkg::word_t       wdata_o;
    logic                redirect_o;
    ex_pkg::word_t       redirect_pc_o;
    ex_pkg::func_t       mem_op_o;
    ex_pkg::word_t       mem_wdata_o;

    // expected output of the current cycle
    exp_t cur;
    logic cur_present;
    exp_t exp_q[$];
    // cycle numbers at which the sink frees a slot
    int   sink_q[$];
    int   model_credits;
    int   held_slots;
    logic accepted;
    logic slow_sink;
    logic [31:0] rng_state;
    int   cycle_count;
    int   err_count;
    int   test_errs;
    int   test_count;
    int   sent_count;

    ex_pkg::func_t alu_funcs[10] = '{ex_pkg::FUNC_ADD, ex_pkg::FUNC_SUB, ex_pkg::FUNC_SLL,
        ex_pkg::FUNC_SLT, ex_pkg::FUNC_SLTU, ex_pkg::FUNC_XOR, ex_pkg::FUNC_SRL,
        ex_pkg::FUNC_SRA, ex_pkg::FUNC_OR, ex_pkg::FUNC_AND};
    ex_pkg::func_t br_funcs[6] = '{ex_pkg::FUNC_BEQ, ex_pkg::FUNC_BNE, ex_pkg::FUNC_BLT,
        ex_pkg::FUNC_BGE, ex_pkg::FUNC_BLTU, ex_pkg::FUNC_BGEU};
    // five loads then three stores
    ex_pkg::func_t mem_funcs[8] = '{ex_pkg::FUNC_LB, ex_pkg::FUNC_LH, ex_pkg::FUNC_LW,
        ex_pkg::FUNC_LBU, ex_pkg::FUNC_LHU, ex_pkg::FUNC_SB, ex_pkg::FUNC_SH, ex_pkg::FUNC_SW};

    ex_stage uut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ends a run that stops making progress
    initial begin
        wait (cycle_count > CYCLE_LIMIT);
        $display("timeout after %0d cycles, the run did not finish", cycle_count);
        $display("Simulation failed");
        $finish;
    end

    function automatic logic [31:0] xorshift32();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    // alu rules with compares and arithmetic shift built from unsigned pieces
    function automatic ex_pkg::word_t alu_model(ex_pkg::func_t func, ex_pkg::word_t a,
                                                ex_pkg::word_t b);
        logic [4:0] sh;
        sh = b[4:0];
        case (func)
            ex_pkg::FUNC_ADD:  return a + b;
            ex_pkg::FUNC_SUB:  return a + ~b + 32'd1;
            ex_pkg::FUNC_SLL:  return a << sh;
            ex_pkg::FUNC_SLT:  return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
            ex_pkg::FUNC_SLTU: return {31'd0, a < b};
            ex_pkg::FUNC_XOR:  return a ^ b;
            ex_pkg::FUNC_SRL:  return a >> sh;
            ex_pkg::FUNC_SRA:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'd0);
            ex_pkg::FUNC_OR:   return a | b;
            ex_pkg::FUNC_AND:  return a & b;
            default:           return 32'd0;
        endcase
    endfunction

    // signed order by flipping the sign bit
    function automatic logic branch_taken(ex_pkg::func_t func, ex_pkg::word_t a,
                                          ex_pkg::word_t b);
        case (func)
            ex_pkg::FUNC_BEQ:  return a == b;
            ex_pkg::FUNC_BNE:  return a != b;
            ex_pkg::FUNC_BLT:  return (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
            ex_pkg::FUNC_BGE:  return (a ^ 32'h8000_0000) >= (b ^ 32'h8000_0000);
            ex_pkg::FUNC_BLTU: return a < b;
            ex_pkg::FUNC_BGEU: return a >= b;
            default:           return 1'b0;
        endcase
    endfunction

    function automatic exp_t model_result(ex_pkg::inst_class_t cls, ex_pkg::func_t func,
        ex_pkg::word_t pc, ex_pkg::word_t imm, ex_pkg::word_t r1, ex_pkg::word_t r2,
        ex_pkg::reg_addr_t wd);
        exp_t e;
        e = '0;
        e.wreg = cls inside {ex_pkg::CLASS_LUI, ex_pkg::CLASS_AUIPC, ex_pkg::CLASS_JAL,
            ex_pkg::CLASS_JALR, ex_pkg::CLASS_LOAD, ex_pkg::CLASS_OP_IMM, ex_pkg::CLASS_OP};
        e.check_mem = cls inside {ex_pkg::CLASS_LOAD, ex_pkg::CLASS_STORE};
        e.check_wdata = e.wreg || cls == ex_pkg::CLASS_STORE;
        e.wd = e.wreg ? wd : 5'd0;
        e.target = pc + imm;
        if (e.check_mem) begin
            e.wdata = r1 + imm;
            e.mem_op = func;
        end
        case (cls)
            ex_pkg::CLASS_LUI:    e.wdata = imm;
            ex_pkg::CLASS_AUIPC:  e.wdata = pc + imm;
            ex_pkg::CLASS_OP:     e.wdata = alu_model(func, r1, r2);
            ex_pkg::CLASS_OP_IMM: e.wdata = alu_model(func, r1, imm);
            ex_pkg::CLASS_BRANCH: e.redirect = branch_taken(func, r1, r2);
            ex_pkg::CLASS_STORE:  e.mem_wdata = r2;
            default: begin
            end
        endcase
        // jumps link and always redirect
        if (cls == ex_pkg::CLASS_JAL || cls == ex_pkg::CLASS_JALR) begin
            e.wdata = pc + ex_pkg::LINK_OFFSET;
            e.redirect = 1'b1;
            e.target = (cls == ex_pkg::CLASS_JALR) ? r1 + imm : pc + imm;
        end
        return e;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("[FAIL] %0t %s expected %h got %h", $time, name, expected, actual);
        err_count++;
    endtask

    task automatic report_problem(input string what);
        $display("error at %0t: %s", $time, what);
        err_count++;
    endtask

    // one clock and then the model credits, the expected result and the sink
    task automatic tick();
        @(posedge clk);
        #1;
        cycle_count++;
        if (accepted) model_credits--;
        // return pulse of the cycle just ended
        if (credit_return_i) model_credits++;
        // a result is due one cycle after every accepting edge
        cur_present = accepted;
        cur = '0;
        // each presented result takes the head of the queue
        if (out_valid_o && exp_q.size() != 0) cur = exp_q.pop_front();
        accepted = 1'b0;
        if (out_valid_o) begin
            sink_q.push_back(cycle_count + (slow_sink ? 8 + int'(xorshift32() % 32'd8)
                                                      : 1 + int'(xorshift32() % 32'd6)));
        end
        credit_return_i = 1'b0;
        if (sink_q.size() != 0 && sink_q[0] <= cycle_count) begin
            credit_return_i = 1'b1;
            void'(sink_q.pop_front());
        end
        held_slots = sink_q.size() + int'(credit_return_i);
    endtask

    // hold the instruction until the stage takes it
    task automatic send(input ex_pkg::inst_class_t cls, input ex_pkg::func_t func,
        input ex_pkg::word_t pc, input ex_pkg::word_t imm, input ex_pkg::word_t r1,
        input ex_pkg::word_t r2, input ex_pkg::reg_addr_t wd);
        in_valid_i = 1'b1;
        inst_class_i = cls;
        func_i = func;
        pc_i = pc;
        imm_i = imm;
        reg1_i = r1;
        reg2_i = r2;
        wd_i = wd;
        while (!in_ready_o) tick();
        exp_q.push_back(model_result(cls, func, pc, imm, r1, r2, wd));
        accepted = 1'b1;
        sent_count++;
        tick();
        in_valid_i = 1'b0;
    endtask

    task automatic random_traffic(input int count);
        ex_pkg::inst_class_t cls;
        ex_pkg::func_t func;
        ex_pkg::word_t r1;
        ex_pkg::word_t r2;
        logic [31:0] pick;
        for (int n = 0; n < count; n++) begin
            pick = xorshift32();
            // idle gap of zero to three cycles
            repeat (pick[9:8]) tick();
            cls = ex_pkg::inst_class_t'(pick[31:16] % 16'd10);
            case (cls)
                ex_pkg::CLASS_BRANCH: func = br_funcs[pick[15:12] % 4'd6];
                ex_pkg::CLASS_LOAD:   func = mem_funcs[pick[15:12] % 4'd5];
                ex_pkg::CLASS_STORE:  func = mem_funcs[5 + pick[15:12] % 4'd3];
                default:              func = alu_funcs[pick[15:12] % 4'd10];
            endcase
            // no immediate form of sub
            if (cls == ex_pkg::CLASS_OP_IMM && func == ex_pkg::FUNC_SUB) func = ex_pkg::FUNC_ADD;
            r1 = xorshift32();
            r2 = (pick[5:4] == 2'd0) ? r1 : xorshift32();
            send(cls, func, xorshift32() & 32'hffff_fffc, xorshift32(), r1, r2, pick[4:0]);
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %s finished, %0d errors", name, err_count - test_errs);
        test_errs = err_count;
        test_count++;
    endtask

    // outputs are compared mid cycle after they settle
    a_valid: assert property (@(negedge clk) disable iff (rst_i) out_valid_o == cur_present)
        else report_mismatch("out_valid_o", {31'd0, cur_present}, {31'd0, out_valid_o});
    a_wreg: assert property (@(negedge clk) disable iff (rst_i) wreg_o == cur.wreg)
        else report_mismatch("wreg_o", {31'd0, cur.wreg}, {31'd0, wreg_o});
    a_redirect: assert property (@(negedge clk) disable iff (rst_i) redirect_o == cur.redirect)
        else report_mismatch("redirect_o", {31'd0, cur.redirect}, {31'd0, redirect_o});
    a_wd: assert property (@(negedge clk) disable iff (rst_i) cur_present |-> wd_o == cur.wd)
        else report_mismatch("wd_o", 32'(cur.wd), 32'(wd_o));
    a_wdata: assert property (@(negedge clk) disable iff (rst_i)
        cur_present && cur.check_wdata |-> wdata_o == cur.wdata)
        else report_mismatch("wdata_o", cur.wdata, wdata_o);
    a_target: assert property (@(negedge clk) disable iff (rst_i)
        cur_present && cur.redirect |-> redirect_pc_o == cur.target)
        else report_mismatch("redirect_pc_o", cur.target, redirect_pc_o);
    a_mem_op: assert property (@(negedge clk) disable iff (rst_i)
        cur_present && cur.check_mem |-> mem_op_o == cur.mem_op)
        else report_mismatch("mem_op_o", 32'(cur.mem_op), 32'(mem_op_o));
    a_mem_wdata: assert property (@(negedge clk) disable iff (rst_i)
        cur_present |-> mem_wdata_o == cur.mem_wdata)
        else report_mismatch("mem_wdata_o", cur.mem_wdata, mem_wdata_o);
    // ready mirrors the remaining credit
    a_ready: assert property (@(negedge clk) disable iff (rst_i)
        in_ready_o == (model_credits != 0))
        else report_mismatch("in_ready_o", {31'd0, model_credits != 0}, {31'd0, in_ready_o});
    a_slots: assert property (@(negedge clk) disable iff (rst_i)
        held_slots <= ex_pkg::CREDIT_MAX)
        else report_problem("memory stage holds more results than it has slots");

    initial begin
        rst_i = 1'b1;
        in_valid_i = 1'b0;
        pc_i = '0;
        inst_class_i = ex_pkg::CLASS_NOP;
        func_i = '0;
        imm_i = '0;
        reg1_i = '0;
        reg2_i = '0;
        wd_i = '0;
        credit_return_i = 1'b0;
        cur = '0;
        cur_present = 1'b0;
        accepted = 1'b0;
        slow_sink = 1'b0;
        rng_state = 32'd68;
        model_credits = ex_pkg::CREDIT_MAX;
        held_slots = 0;
        cycle_count = 0;
        err_count = 0;
        test_errs = 0;
        test_count = 0;
        sent_count = 0;
        repeat (2) tick();
        rst_i = 1'b0;
        tick();
        finish_test("reset");
        // negative operands, sign boundary, shift amounts with upper bits set
        for (int f = 0; f < 10; f++) begin
            send(ex_pkg::CLASS_OP, alu_funcs[f], 32'h100, 32'h0, 32'hffff_fffb, 32'h3, 5'd1);
            send(ex_pkg::CLASS_OP, alu_funcs[f], 32'h104, 32'h0, 32'h8000_0000, 32'h7fff_ffff,
                 5'd2);
            send(ex_pkg::CLASS_OP, alu_funcs[f], 32'h108, 32'h0, 32'hf0f0_1234, 32'hffff_ffe5,
                 5'd3);
            if (alu_funcs[f] != ex_pkg::FUNC_SUB) begin
                send(ex_pkg::CLASS_OP_IMM, alu_funcs[f], 32'h10c, 32'hffff_fff8, 32'h8000_0010,
                     32'h0, 5'd4);
                send(ex_pkg::CLASS_OP_IMM, alu_funcs[f], 32'h110, 32'h0000_07e4, 32'h8000_0010,
                     32'h0, 5'd5);
            end
        end
        finish_test("alu");
        random_traffic(25);
        send(ex_pkg::CLASS_LUI, ex_pkg::FUNC_ADD, 32'h200, 32'h1234_5000, 32'h0, 32'h0, 5'd6);
        send(ex_pkg::CLASS_AUIPC, ex_pkg::FUNC_ADD, 32'h1000, 32'hffff_f000, 32'h0, 32'h0, 5'd7);
        send(ex_pkg::CLASS_JAL, ex_pkg::FUNC_ADD, 32'h2000, 32'h800, 32'h0, 32'h0, 5'd1);
        send(ex_pkg::CLASS_JAL, ex_pkg::FUNC_ADD, 32'h2000, 32'hffff_fff0, 32'h0, 32'h0, 5'd1);
        send(ex_pkg::CLASS_JALR, ex_pkg::FUNC_ADD, 32'h2400, 32'hffff_fffc, 32'h3003, 32'h0, 5'd8);
        finish_test("upper and jump");
        random_traffic(25);
        // equal operands and both sign boundary orders
        for (int f = 0; f < 6; f++) begin
            send(ex_pkg::CLASS_BRANCH, br_funcs[f], 32'h400, 32'h40, 32'h5, 32'h5, 5'd9);
            send(ex_pkg::CLASS_BRANCH, br_funcs[f], 32'h404, 32'hffff_ffc0, 32'h7fff_ffff,
                 32'h8000_0000, 5'd9);
            send(ex_pkg::CLASS_BRANCH, br_funcs[f], 32'h408, 32'h80, 32'h8000_0000,
                 32'h7fff_ffff, 5'd9);
        end
        finish_test("branch");
        random_traffic(25);
        for (int f = 0; f < 8; f++) begin
            send(f < 5 ? ex_pkg::CLASS_LOAD : ex_pkg::CLASS_STORE, mem_funcs[f], 32'h800,
                 32'hffff_fffc, 32'h1000_0000 + f, 32'hcafe_0000 + f, 5'd10);
        end
        finish_test("load and store");
        random_traffic(25);
        // long sink delays keep the credit count at zero most of the time
        slow_sink = 1'b1;
        random_traffic(12);
        slow_sink = 1'b0;
        finish_test("back-pressure");
        random_traffic(25);
        // drain until the sink has handed back every credit
        while (sink_q.size() != 0 || credit_return_i) tick();
        if (exp_q.size() != 0) report_problem("results still expected at the end of the run");
        if (model_credits != ex_pkg::CREDIT_MAX) report_problem("not all credits came back");
        finish_test("drain");
        $display("%0d tests, %0d instructions, %0d errors", test_count, sent_count, err_count);
        if (err_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
hw/ex_pkg.sv
hw/ex_alu.sv
hw/ex_branch_unit.sv
hw/ex_credit_reg.sv
hw/ex_stage.sv
test/tb_ex_stage.sv

// ==== run.sh ====
#!/bin/sh
# build and run the ex_stage testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ex_stage \
    -f list.f \
    -o sim_ex_stage

# the log decides the result
./obj_dir/sim_ex_stage | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
    echo "run.sh: pass"
else
    echo "run.sh: fail"
    exit 1
fi
